/* common/matty_defs.svh */
/*
 * widths, register map, sync byte and reset defaults
 * for the shot timing core
 */
`ifndef MATTY_DEFS_SVH
`define MATTY_DEFS_SVH

// widths
`define MATTY_BYTE_W    8
`define MATTY_CNT_W     24
`define MATTY_TIME_W    16
`define MATTY_ADDR_W    19
`define MATTY_ADC_W     10
`define MATTY_WORD_W    16

`define MATTY_SYNC_BYTE 8'hAA  // opens a config frame

// register map
`define MATTY_REG_PON_POFF  8'hD0
`define MATTY_REG_PON       8'hE0
`define MATTY_REG_POFF_HI   8'hE1
`define MATTY_REG_POFF_LO   8'hE2
`define MATTY_REG_DELAY_HI  8'hE3
`define MATTY_REG_DELAY_LO  8'hE4
`define MATTY_REG_ACQ_HI    8'hE5
`define MATTY_REG_ACQ_LO    8'hE6
`define MATTY_REG_PERIOD_HI 8'hE7
`define MATTY_REG_PERIOD_MID 8'hE8
`define MATTY_REG_PERIOD_LO 8'hE9
`define MATTY_REG_SOFT_TRIG 8'hEA
`define MATTY_REG_CONT      8'hEB
`define MATTY_REG_ADC_DIV   8'hED
`define MATTY_REG_REPEAT    8'hEE
`define MATTY_REG_PTR_RST   8'hEF

// reset defaults, in pll_clk128 cycles unless noted
`define MATTY_DEF_PON       8'h14
`define MATTY_DEF_PON_POFF  8'h0A
`define MATTY_DEF_POFF_END  16'h00C8
`define MATTY_DEF_ACQ_DELAY 16'h02BC
`define MATTY_DEF_ACQ_END   16'h32C8
`define MATTY_DEF_PERIOD    24'h0186A0
`define MATTY_DEF_REPEAT    8'h0A   // shots per continuous burst
`define MATTY_DEF_ADC_DIV   8'h03

`define MATTY_TRIG_HOLD     24'd16  // internal trigger drops here

`endif

/* common/matty_pkg.sv */
/*
 * shared types: configured timing register set,
 * SRAM sample word fields and its raw/decoded union
 */
`default_nettype none
`include "matty_defs.svh"

package matty_pkg;

  // everything the byte stream can set
  typedef struct packed {
    logic [`MATTY_BYTE_W-1:0] pon_len;
    logic [`MATTY_BYTE_W-1:0] pon_poff;
    logic [`MATTY_TIME_W-1:0] poff_end;
    logic [`MATTY_TIME_W-1:0] acq_delay;
    logic [`MATTY_TIME_W-1:0] acq_end;
    logic [`MATTY_CNT_W-1:0]  period;
    logic [`MATTY_BYTE_W-1:0] repeat_n;   // shots per burst
    logic [`MATTY_BYTE_W-1:0] adc_div;
    logic                     continuous;
    logic                     soft_trig;
    logic                     ptr_reset;
  } timing_regs_t;

  // sample word layout, msb first
  typedef struct packed {
    logic       marker;
    logic [1:0] trig_count;
    logic       tour2;
    logic       tour1;
    logic [2:0] adc_hi;
    logic       zero;
    logic [6:0] adc_lo;
  } sample_fields_t;

  typedef union packed {
    logic [`MATTY_WORD_W-1:0] raw;
    sample_fields_t           fields;
  } ram_word_u;

endpackage

`default_nettype wire

/* source/config_regs.sv */
/*
 * byte stream parser (sync, address, value)
 * and the timing register file
 */
`default_nettype none
`include "matty_defs.svh"

module config_regs (
  input  wire                     pll_clk128,
  input  wire                     reset,
  input  wire [`MATTY_BYTE_W-1:0] i_rx_byte,
  input  wire                     i_rx_valid,
  output matty_pkg::timing_regs_t o_regs
);

  localparam logic [1:0] PH_SYNC  = 2'b00;
  localparam logic [1:0] PH_ADDR  = 2'b01;
  localparam logic [1:0] PH_VALUE = 2'b10;

  logic [1:0]               phase_q;
  logic [`MATTY_BYTE_W-1:0] addr_q;
  matty_pkg::timing_regs_t  regs_q;

  assign o_regs = regs_q;

  ////////////////////////////////////////
  // frame parser and register writes
  ////////////////////////////////////////
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      phase_q           <= PH_SYNC;
      addr_q            <= '0;
      regs_q.pon_len    <= `MATTY_DEF_PON;
      regs_q.pon_poff   <= `MATTY_DEF_PON_POFF;
      regs_q.poff_end   <= `MATTY_DEF_POFF_END;
      regs_q.acq_delay  <= `MATTY_DEF_ACQ_DELAY;
      regs_q.acq_end    <= `MATTY_DEF_ACQ_END;
      regs_q.period     <= `MATTY_DEF_PERIOD;
      regs_q.repeat_n   <= `MATTY_DEF_REPEAT;
      regs_q.adc_div    <= `MATTY_DEF_ADC_DIV;
      regs_q.continuous <= 1'b0;
      regs_q.soft_trig  <= 1'b0;
      regs_q.ptr_reset  <= 1'b0;
    end else if (i_rx_valid) begin
      case (phase_q)
        PH_SYNC: begin
          if (i_rx_byte == `MATTY_SYNC_BYTE) phase_q <= PH_ADDR;
          regs_q.soft_trig <= 1'b0;  // soft trigger is a one-frame pulse
        end
        PH_ADDR: begin
          addr_q           <= i_rx_byte;
          phase_q          <= PH_VALUE;
          regs_q.ptr_reset <= 1'b0;
        end
        PH_VALUE: begin
          phase_q <= PH_SYNC;
          case (addr_q)
            `MATTY_REG_PON_POFF:   regs_q.pon_poff         <= i_rx_byte;
            `MATTY_REG_PON:        regs_q.pon_len          <= i_rx_byte;
            `MATTY_REG_POFF_HI:    regs_q.poff_end[15:8]   <= i_rx_byte;
            `MATTY_REG_POFF_LO:    regs_q.poff_end[7:0]    <= i_rx_byte;
            `MATTY_REG_DELAY_HI:   regs_q.acq_delay[15:8]  <= i_rx_byte;
            `MATTY_REG_DELAY_LO:   regs_q.acq_delay[7:0]   <= i_rx_byte;
            `MATTY_REG_ACQ_HI:     regs_q.acq_end[15:8]    <= i_rx_byte;
            `MATTY_REG_ACQ_LO:     regs_q.acq_end[7:0]     <= i_rx_byte;
            `MATTY_REG_PERIOD_HI:  regs_q.period[23:16]    <= i_rx_byte;
            `MATTY_REG_PERIOD_MID: regs_q.period[15:8]     <= i_rx_byte;
            `MATTY_REG_PERIOD_LO:  regs_q.period[7:0]      <= i_rx_byte;
            `MATTY_REG_SOFT_TRIG:  regs_q.soft_trig        <= i_rx_byte[0];
            `MATTY_REG_CONT:       regs_q.continuous       <= i_rx_byte[0];
            `MATTY_REG_ADC_DIV:    regs_q.adc_div          <= i_rx_byte;
            `MATTY_REG_REPEAT:     regs_q.repeat_n         <= i_rx_byte;
            `MATTY_REG_PTR_RST:    regs_q.ptr_reset        <= i_rx_byte[0];
            default: ;  // unknown address, drop it
          endcase
        end
        default: begin
          phase_q <= PH_SYNC;
          addr_q  <= '0;
        end
      endcase
    end
  end

  // the fourth phase code is never entered
  a_phase_legal : assert property (
    @(posedge pll_clk128) disable iff (!reset) phase_q != 2'b11
  );

endmodule

`default_nettype wire

/* sequencer/shot_trigger.sv */
/*
 * trigger edge detect, repeat counter for continuous
 * bursts, acquisition flag and shot frame counter
 */
`default_nettype none
`include "matty_defs.svh"

module shot_trigger (
  input  wire                      pll_clk128,
  input  wire                      reset,
  input  wire                      i_trig_ext,
  input  wire                      i_trig_host,
  input  wire                      i_soft_trig,
  input  wire                      i_continuous,
  input  wire [`MATTY_BYTE_W-1:0]  i_repeat,
  input  wire [`MATTY_CNT_W-1:0]   i_period,
  input  wire                      i_period_gate,
  output logic [`MATTY_CNT_W-1:0]  o_frame_count,
  output logic                     o_acq_active,
  output logic [1:0]               o_trig_count
);

  logic                     trig_in;
  logic                     trig_prev_q;
  logic                     soft_prev_q;
  logic                     gate_prev_q;
  logic                     trig_level_q;
  logic [`MATTY_BYTE_W-1:0] rep_cnt_q;
  logic [`MATTY_CNT_W-1:0]  frame_q;
  logic                     start_evt;  // external or soft
  logic                     retrig_evt; // end of period in continuous mode
  logic                     hold_end;

  assign trig_in    = i_trig_ext | i_trig_host;
  assign start_evt  = (trig_in & ~trig_prev_q) | (i_soft_trig & ~soft_prev_q);
  assign retrig_evt = i_continuous & gate_prev_q & ~i_period_gate &
                      (rep_cnt_q < i_repeat - 8'd1);
  assign hold_end   = (frame_q == `MATTY_TRIG_HOLD);

  ////////////////////////////////////////
  // trigger level and repeat count
  ////////////////////////////////////////
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      trig_prev_q  <= 1'b0;
      soft_prev_q  <= 1'b0;
      gate_prev_q  <= 1'b0;
      trig_level_q <= 1'b0;
      rep_cnt_q    <= '0;
    end else begin
      trig_prev_q <= trig_in;
      soft_prev_q <= i_soft_trig;
      gate_prev_q <= i_period_gate;

      if ((start_evt | retrig_evt) && !hold_end) trig_level_q <= 1'b1;
      else if (hold_end) trig_level_q <= 1'b0;

      if (start_evt) rep_cnt_q <= '0;  // a fresh burst
      else if (retrig_evt && !hold_end) rep_cnt_q <= rep_cnt_q + 8'd1;
    end
  end

  // high from trigger through the end of the period
  assign o_acq_active = trig_level_q | (frame_q > 24'd1 && frame_q <= i_period);

  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) frame_q <= '0;
    else if (o_acq_active) frame_q <= frame_q + 24'd1;
    else frame_q <= '0;
  end

  assign o_frame_count = frame_q;
  assign o_trig_count  = rep_cnt_q[1:0];

  // each shot starts counting from zero
  a_frame_restart : assert property (
    @(posedge pll_clk128) disable iff (!reset) !o_acq_active |=> frame_q == '0
  );

endmodule

`default_nettype wire

/* sequencer/shot_windows.sv */
/*
 * pon, poff, acquisition window and period gate,
 * decoded from the shot frame counter
 */
`default_nettype none
`include "matty_defs.svh"

module shot_windows (
  input  wire [`MATTY_CNT_W-1:0] i_frame_count,
  input  wire matty_pkg::timing_regs_t i_regs,
  output logic                   o_pon,
  output logic                   o_poff,
  output logic                   o_acq_window,
  output logic                   o_period_gate
);

  logic counting;  // counter past the idle value

  assign counting = (i_frame_count != '0);

  ////////////////////////////////////////
  // gate decode
  ////////////////////////////////////////

  // pulser on for the first pon_len counts
  assign o_pon = counting && (i_frame_count <= i_regs.pon_len);

  // poff is active low between the two marks
  assign o_poff = !((i_frame_count > i_regs.pon_poff) &&
                    (i_frame_count < i_regs.poff_end));

  assign o_acq_window = (i_frame_count > i_regs.acq_delay) &&
                        (i_frame_count < i_regs.acq_end);

  // whole shot, used for continuous retrigger
  assign o_period_gate = counting && (i_frame_count <= i_regs.period);

endmodule

`default_nettype wire

/* acquisition/adc_clock_gen.sv */
/*
 * ADC clock divider, runs only inside
 * the acquisition window
 */
`default_nettype none
`include "matty_defs.svh"

module adc_clock_gen (
  input  wire                     pll_clk128,
  input  wire                     reset,
  input  wire                     i_acq_window,
  input  wire [`MATTY_BYTE_W-1:0] i_adc_div,
  output logic                    o_adc_clk
);

  logic [`MATTY_BYTE_W-1:0] div_cnt_q;
  logic                     adc_clk_q;

  // half period is adc_div + 1 cycles
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      div_cnt_q <= '0;
      adc_clk_q <= 1'b0;
    end else if (i_acq_window) begin
      if (div_cnt_q == i_adc_div) begin
        div_cnt_q <= '0;
        adc_clk_q <= ~adc_clk_q;
      end else begin
        div_cnt_q <= div_cnt_q + 8'd1;
      end
    end else begin
      div_cnt_q <= '0;     // same phase on every shot
      adc_clk_q <= 1'b0;
    end
  end

  assign o_adc_clk = adc_clk_q;

endmodule

`default_nettype wire

/* acquisition/sample_writer.sv */
/*
 * SRAM write path: write pointer, sample word
 * assembly, write strobe and data bus enable
 */
`default_nettype none
`include "matty_defs.svh"

module sample_writer (
  input  wire                      pll_clk128,
  input  wire                      reset,
  input  wire                      i_acq_window,
  input  wire                      i_adc_clk,
  input  wire [`MATTY_ADC_W-1:0]   i_adc,
  input  wire                      i_tour1,
  input  wire                      i_tour2,
  input  wire [1:0]                i_trig_count,
  input  wire                      i_ptr_reset,
  output logic [`MATTY_ADDR_W-1:0] o_ram_addr,
  output logic [`MATTY_WORD_W-1:0] o_ram_data,
  output logic                     o_ram_data_en,
  output logic                     o_ram_we_n
);

  logic                     adc_clk_prev_q;
  logic                     sample_now;
  logic [`MATTY_ADDR_W-1:0] wr_ptr_q;
  logic [`MATTY_ADDR_W-1:0] addr_q;
  logic                     data_en_q;
  matty_pkg::ram_word_u     word_d;
  matty_pkg::ram_word_u     word_q;

  assign sample_now = i_acq_window & i_adc_clk & ~adc_clk_prev_q;

  // adc bit 7 sits above the zero bit
  always_comb begin
    word_d.fields.marker     = 1'b1;
    word_d.fields.trig_count = i_trig_count;
    word_d.fields.tour2      = i_tour2;
    word_d.fields.tour1      = i_tour1;
    word_d.fields.adc_hi     = i_adc[9:7];
    word_d.fields.zero       = 1'b0;
    word_d.fields.adc_lo     = i_adc[6:0];
  end

  ////////////////////////////////////////
  // write pointer and bus registers
  ////////////////////////////////////////
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      adc_clk_prev_q <= 1'b0;
      wr_ptr_q       <= '0;
      addr_q         <= '0;
      data_en_q      <= 1'b0;
      word_q.raw     <= '0;
    end else begin
      adc_clk_prev_q <= i_adc_clk;
      if (sample_now) begin
        addr_q    <= wr_ptr_q;
        wr_ptr_q  <= wr_ptr_q + 19'd1;
        word_q    <= word_d;
        data_en_q <= 1'b1;
      end else if (!i_acq_window) begin
        data_en_q <= 1'b0;  // release the bus
      end
      if (i_ptr_reset) wr_ptr_q <= '0;
    end
  end

  assign o_ram_addr    = addr_q;
  assign o_ram_data    = word_q.raw;
  assign o_ram_data_en = data_en_q;
  assign o_ram_we_n    = i_acq_window ? i_adc_clk : 1'b1;  // write on adc low phase

  a_we_idle : assert property (
    @(posedge pll_clk128) disable iff (!reset) !i_acq_window |-> o_ram_we_n
  );

endmodule

`default_nettype wire

/* source/matty_top.sv */
/*
 * shot timing core top: config registers, shot
 * sequencer, ADC clock and SRAM writer
 */
`default_nettype none
`include "matty_defs.svh"

module matty_top (
  input  wire                      pll_clk128,
  input  wire                      reset,
  input  wire [`MATTY_BYTE_W-1:0]  i_rx_byte,
  input  wire                      i_rx_valid,
  input  wire                      i_trig_ext,
  input  wire                      i_trig_host,
  input  wire [`MATTY_ADC_W-1:0]   i_adc,
  input  wire                      i_tour1,
  input  wire                      i_tour2,
  output wire                      o_pon,
  output wire                      o_poff,
  output wire                      o_adc_clk,
  output wire [`MATTY_ADDR_W-1:0]  o_ram_addr,
  output wire [`MATTY_WORD_W-1:0]  o_ram_data,
  output wire                      o_ram_data_en,
  output wire                      o_ram_we_n,
  output wire                      o_led_acq,
  output wire                      o_led_mode
);

  wire matty_pkg::timing_regs_t regs;
  wire [`MATTY_CNT_W-1:0]       frame_count;
  wire [1:0]                    trig_count;
  wire                          acq_window;
  wire                          period_gate;

  assign o_led_mode = regs.continuous;

  config_regs u_config_regs (
    .pll_clk128 (pll_clk128),
    .reset      (reset),
    .i_rx_byte  (i_rx_byte),
    .i_rx_valid (i_rx_valid),
    .o_regs     (regs)
  );

  shot_trigger u_shot_trigger (
    .pll_clk128    (pll_clk128),
    .reset         (reset),
    .i_trig_ext    (i_trig_ext),
    .i_trig_host   (i_trig_host),
    .i_soft_trig   (regs.soft_trig),
    .i_continuous  (regs.continuous),
    .i_repeat      (regs.repeat_n),
    .i_period      (regs.period),
    .i_period_gate (period_gate),
    .o_frame_count (frame_count),
    .o_acq_active  (o_led_acq),
    .o_trig_count  (trig_count)
  );

  shot_windows u_shot_windows (
    .i_frame_count (frame_count),
    .i_regs        (regs),
    .o_pon         (o_pon),
    .o_poff        (o_poff),
    .o_acq_window  (acq_window),
    .o_period_gate (period_gate)
  );

  adc_clock_gen u_adc_clock_gen (
    .pll_clk128   (pll_clk128),
    .reset        (reset),
    .i_acq_window (acq_window),
    .i_adc_div    (regs.adc_div),
    .o_adc_clk    (o_adc_clk)
  );

  sample_writer u_sample_writer (
    .pll_clk128    (pll_clk128),
    .reset         (reset),
    .i_acq_window  (acq_window),
    .i_adc_clk     (o_adc_clk),
    .i_adc         (i_adc),
    .i_tour1       (i_tour1),
    .i_tour2       (i_tour2),
    .i_trig_count  (trig_count),
    .i_ptr_reset   (regs.ptr_reset),
    .o_ram_addr    (o_ram_addr),
    .o_ram_data    (o_ram_data),
    .o_ram_data_en (o_ram_data_en),
    .o_ram_we_n    (o_ram_we_n)
  );

endmodule

`default_nettype wire

/* test/tb_matty_tasks.svh */
/*
 * testbench tasks: byte and trigger drivers, monitor
 * clear, compare tasks and the five directed tests
 */
`ifndef TB_MATTY_TASKS_SVH
`define TB_MATTY_TASKS_SVH

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////
  task automatic send_byte(input logic [`MATTY_BYTE_W-1:0] b);
    @(negedge pll_clk128);
    i_rx_byte  = b;
    i_rx_valid = 1'b1;
    @(negedge pll_clk128);
    i_rx_valid = 1'b0;
    @(negedge pll_clk128);  // idle gap
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] value);
    send_byte(`MATTY_SYNC_BYTE);
    send_byte(addr);
    send_byte(value);
  endtask

  task automatic set_period(input logic [`MATTY_CNT_W-1:0] p);
    write_reg(`MATTY_REG_PERIOD_HI, p[23:16]);
    write_reg(`MATTY_REG_PERIOD_MID, p[15:8]);
    write_reg(`MATTY_REG_PERIOD_LO, p[7:0]);
  endtask

  task automatic pulse_trigger(input bit use_host);
    @(negedge pll_clk128);
    if (use_host) i_trig_host = 1'b1;
    else i_trig_ext = 1'b1;
    repeat (3) @(negedge pll_clk128);
    i_trig_ext  = 1'b0;
    i_trig_host = 1'b0;
  endtask

  task automatic hold_adc_inputs();
    held_adc   = 10'($urandom());
    held_tours = 2'($urandom());
    @(negedge pll_clk128);
    i_adc   = held_adc;
    i_tour1 = held_tours[0];
    i_tour2 = held_tours[1];
  endtask

  task automatic clear_monitors();
    @(posedge pll_clk128);
    pon_cycles      = 0;
    poff_low_cycles = 0;
    adc_rises       = 0;
    led_rises       = 0;
    en_idle_cycles  = 0;
    wr_addr.delete();
    wr_word.delete();
  endtask

  // shot is over once the acquisition LED stays low a few cycles
  task automatic wait_shot_end(input int limit);
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (!o_led_acq && n < limit) begin
      @(negedge pll_clk128);
      n++;
    end
    while (quiet < 4 && n < limit) begin
      @(negedge pll_clk128);
      n++;
      if (o_led_acq) quiet = 0;
      else quiet++;
    end
    if (n >= limit) begin
      errors++;
      $display("shot did not start or end within %0d cycles", limit);
    end
    @(posedge pll_clk128);
  endtask

  ////////////////////////////////////////
  // compare tasks and expected values
  ////////////////////////////////////////
  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    errors++;
    $display("FAILED %s: got %h expected %h", name, got, exp);
  endtask

  task automatic check_word(input string name, input matty_pkg::ram_word_u got,
                            input matty_pkg::ram_word_u exp);
    matty_pkg::sample_fields_t g;
    matty_pkg::sample_fields_t e;
    g = got.fields;
    e = exp.fields;
    checks++;
    if (g.marker !== e.marker) report_mismatch({name, ".marker"}, 16'(g.marker), 16'(e.marker));
    if (g.trig_count !== e.trig_count)
      report_mismatch({name, ".trig_count"}, 16'(g.trig_count), 16'(e.trig_count));
    if (g.tour2 !== e.tour2) report_mismatch({name, ".tour2"}, 16'(g.tour2), 16'(e.tour2));
    if (g.tour1 !== e.tour1) report_mismatch({name, ".tour1"}, 16'(g.tour1), 16'(e.tour1));
    if (g.adc_hi !== e.adc_hi) report_mismatch({name, ".adc_hi"}, 16'(g.adc_hi), 16'(e.adc_hi));
    if (g.zero !== e.zero) report_mismatch({name, ".zero"}, 16'(g.zero), 16'(e.zero));
    if (g.adc_lo !== e.adc_lo) report_mismatch({name, ".adc_lo"}, 16'(g.adc_lo), 16'(e.adc_lo));
  endtask

  // window spans the counts strictly between delay and end
  function automatic int adc_rises_in_window(input int delay, input int win_end, input int div);
    int width;
    int toggles;
    width   = win_end - delay - 1;
    toggles = width / (div + 1);
    return (toggles + 1) / 2;
  endfunction

  function automatic matty_pkg::ram_word_u make_sample_word(input logic [1:0] tc);
    matty_pkg::ram_word_u w;
    w.fields.marker     = 1'b1;
    w.fields.trig_count = tc;
    w.fields.tour2      = held_tours[1];
    w.fields.tour1      = held_tours[0];
    w.fields.adc_hi     = held_adc[9:7];
    w.fields.zero       = 1'b0;
    w.fields.adc_lo     = held_adc[6:0];
    return w;
  endfunction

  // addresses run up from first_addr, trig count steps once per shot
  task automatic check_writes(input int first_addr, input int per_shot);
    int i;
    for (i = 0; i < wr_addr.size(); i++) begin
      check_count("o_ram_addr", int'(wr_addr[i]), first_addr + i);
      check_word("o_ram_data", wr_word[i], make_sample_word(2'(i / per_shot)));
    end
    check_count("o_ram_data_en cycles outside shot", en_idle_cycles, 0);
    check_bit("o_ram_data_en", o_ram_data_en, 1'b0);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_idle_and_stray_byte();
    check_bit("o_pon", o_pon, 1'b0);
    check_bit("o_poff", o_poff, 1'b1);
    check_bit("o_adc_clk", o_adc_clk, 1'b0);
    check_bit("o_ram_we_n", o_ram_we_n, 1'b1);
    check_bit("o_ram_data_en", o_ram_data_en, 1'b0);
    check_bit("o_led_acq", o_led_acq, 1'b0);
    check_bit("o_led_mode", o_led_mode, 1'b0);
    set_period(24'd100);
    send_byte(`MATTY_REG_PON);  // no sync in front, both dropped
    send_byte(8'h05);
    clear_monitors();
    pulse_trigger(1'b0);
    wait_shot_end(SHOT_CYCLES);
    check_count("o_led_acq rises", led_rises, 1);
    check_count("o_pon width", pon_cycles, int'(`MATTY_DEF_PON));
  endtask

  task automatic test_pulser_gates();
    int pon_len;
    int pon_poff;
    int poff_end;
    pon_len  = 8;
    pon_poff = 12;
    poff_end = 48;
    write_reg(`MATTY_REG_PON, 8'(pon_len));
    write_reg(`MATTY_REG_PON_POFF, 8'(pon_poff));
    write_reg(`MATTY_REG_POFF_HI, 8'(poff_end >> 8));
    write_reg(`MATTY_REG_POFF_LO, 8'(poff_end));
    clear_monitors();
    pulse_trigger(1'b0);
    wait_shot_end(SHOT_CYCLES);
    check_count("o_pon width", pon_cycles, pon_len);
    check_count("o_poff low width", poff_low_cycles, poff_end - pon_poff - 1);
  endtask

  // window of 21 counts so the last ADC half period closes inside it
  task automatic test_sample_writes();
    int exp_rises;
    write_reg(`MATTY_REG_DELAY_HI, 8'h00);
    write_reg(`MATTY_REG_DELAY_LO, 8'd40);
    write_reg(`MATTY_REG_ACQ_HI, 8'h00);
    write_reg(`MATTY_REG_ACQ_LO, 8'd62);
    write_reg(`MATTY_REG_ADC_DIV, 8'd1);
    hold_adc_inputs();
    exp_rises = adc_rises_in_window(40, 62, 1);
    clear_monitors();
    pulse_trigger(1'b1);
    wait_shot_end(SHOT_CYCLES);
    check_count("o_adc_clk rises", adc_rises, exp_rises);
    check_count("ram writes", wr_addr.size(), exp_rises);
    check_writes(ptr_model, exp_rises);
    ptr_model += wr_addr.size();
  endtask

  task automatic test_continuous_burst();
    int reps;
    int per_shot;
    reps     = 3;
    per_shot = adc_rises_in_window(40, 62, 1);
    write_reg(`MATTY_REG_REPEAT, 8'(reps));
    write_reg(`MATTY_REG_CONT, 8'h01);
    check_bit("o_led_mode", o_led_mode, 1'b1);
    clear_monitors();
    pulse_trigger(1'b0);
    wait_shot_end(reps * SHOT_CYCLES);
    check_count("o_led_acq rises", led_rises, reps);
    check_count("ram writes", wr_addr.size(), reps * per_shot);
    check_writes(ptr_model, per_shot);
    ptr_model += wr_addr.size();
    write_reg(`MATTY_REG_CONT, 8'h00);
    check_bit("o_led_mode", o_led_mode, 1'b0);
  endtask

  task automatic test_soft_trigger_ptr_reset();
    int per_shot;
    per_shot = adc_rises_in_window(40, 62, 1);
    clear_monitors();
    write_reg(`MATTY_REG_SOFT_TRIG, 8'h01);
    wait_shot_end(SHOT_CYCLES);
    check_count("o_led_acq rises", led_rises, 1);
    check_count("ram writes", wr_addr.size(), per_shot);
    check_writes(ptr_model, per_shot);  // pointer carries on from earlier shots
    write_reg(`MATTY_REG_PTR_RST, 8'h01);
    clear_monitors();
    write_reg(`MATTY_REG_SOFT_TRIG, 8'h01);  // address byte also drops the pointer reset
    wait_shot_end(SHOT_CYCLES);
    check_count("o_led_acq rises", led_rises, 1);
    check_count("ram writes", wr_addr.size(), per_shot);
    check_writes(0, per_shot);
    ptr_model = wr_addr.size();
  endtask

`endif

/* test/tb_matty.sv */
/*
 * shot timing core testbench: clock, reset, DUT,
 * output monitors, watchdog and test sequence
 */
`default_nettype none
`include "matty_defs.svh"

module tb_matty;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS      = 8;
  localparam int SHOT_CYCLES = 140;  // short period plus trigger hold and idle tail
  localparam int NUM_SHOTS   = 8;
  localparam int CFG_CYCLES  = 600;
  localparam int LIMIT_NS    = (NUM_SHOTS * SHOT_CYCLES + CFG_CYCLES + 2000) * CLK_NS;

  logic                      pll_clk128;
  logic                      reset;
  logic [`MATTY_BYTE_W-1:0]  i_rx_byte;
  logic                      i_rx_valid;
  logic                      i_trig_ext;
  logic                      i_trig_host;
  logic [`MATTY_ADC_W-1:0]   i_adc;
  logic                      i_tour1;
  logic                      i_tour2;
  wire                       o_pon;
  wire                       o_poff;
  wire                       o_adc_clk;
  wire  [`MATTY_ADDR_W-1:0]  o_ram_addr;
  wire  [`MATTY_WORD_W-1:0]  o_ram_data;
  wire                       o_ram_data_en;
  wire                       o_ram_we_n;
  wire                       o_led_acq;
  wire                       o_led_mode;

  int errors;
  int checks;
  int ptr_model;  // next SRAM address the writer should use

  // held sample inputs
  logic [`MATTY_ADC_W-1:0] held_adc;
  logic [1:0]              held_tours;

  // monitor state
  int                       pon_cycles;
  int                       poff_low_cycles;
  int                       adc_rises;
  int                       led_rises;
  int                       en_idle_cycles;
  logic                     adc_prev;
  logic                     led_prev;
  logic                     wr_prev;
  logic                     wr_now;
  logic [`MATTY_ADDR_W-1:0] wr_addr[$];
  matty_pkg::ram_word_u     wr_word[$];
  matty_pkg::ram_word_u     seen_word;

  always #(CLK_NS / 2) pll_clk128 = ~pll_clk128;

  matty_top dut_i (
    .pll_clk128    (pll_clk128),
    .reset         (reset),
    .i_rx_byte     (i_rx_byte),
    .i_rx_valid    (i_rx_valid),
    .i_trig_ext    (i_trig_ext),
    .i_trig_host   (i_trig_host),
    .i_adc         (i_adc),
    .i_tour1       (i_tour1),
    .i_tour2       (i_tour2),
    .o_pon         (o_pon),
    .o_poff        (o_poff),
    .o_adc_clk     (o_adc_clk),
    .o_ram_addr    (o_ram_addr),
    .o_ram_data    (o_ram_data),
    .o_ram_data_en (o_ram_data_en),
    .o_ram_we_n    (o_ram_we_n),
    .o_led_acq     (o_led_acq),
    .o_led_mode    (o_led_mode)
  );

  ////////////////////////////////////////
  // monitors, sampled mid cycle
  ////////////////////////////////////////
  assign wr_now = !o_ram_we_n && o_ram_data_en;  // SRAM write pulse with bus driven

  always @(negedge pll_clk128) begin
    if (o_pon) pon_cycles++;
    if (!o_poff) poff_low_cycles++;
    if (o_adc_clk && !adc_prev) adc_rises++;
    if (o_led_acq && !led_prev) led_rises++;
    if (o_ram_data_en && !o_led_acq) en_idle_cycles++;
    if (wr_now && !wr_prev) begin
      seen_word.raw = o_ram_data;
      wr_addr.push_back(o_ram_addr);
      wr_word.push_back(seen_word);
    end
    adc_prev = o_adc_clk;
    led_prev = o_led_acq;
    wr_prev  = wr_now;
  end

  `include "tb_matty_tasks.svh"

  // watchdog
  initial begin
    #(LIMIT_NS);
    $display("watchdog expired after %0d ns, the test sequence hung", LIMIT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'hc7de_1e42));
    pll_clk128  = 1'b0;
    reset       = 1'b0;
    i_rx_byte   = '0;
    i_rx_valid  = 1'b0;
    i_trig_ext  = 1'b0;
    i_trig_host = 1'b0;
    i_adc       = '0;
    i_tour1     = 1'b0;
    i_tour2     = 1'b0;
    held_adc    = '0;
    held_tours  = '0;
    errors      = 0;
    checks      = 0;
    ptr_model   = 0;
    adc_prev    = 1'b0;
    led_prev    = 1'b0;
    wr_prev     = 1'b0;
    repeat (10) @(negedge pll_clk128);
    reset = 1'b1;
    repeat (2) @(negedge pll_clk128);

    test_idle_and_stray_byte();
    test_pulser_gates();
    test_sample_writes();
    test_continuous_burst();
    test_soft_trigger_ptr_reset();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
+incdir+test
common/matty_pkg.sv
source/config_regs.sv
sequencer/shot_trigger.sv
sequencer/shot_windows.sv
acquisition/adc_clock_gen.sv
acquisition/sample_writer.sv
source/matty_top.sv
test/tb_matty.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the shot timing core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matty -f build.f --Mdir obj_dir

./obj_dir/Vtb_matty | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "run_sim: pass"
else
  echo "run_sim: fail"
  exit 1
fi
